// File: all.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
reg_file.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
mips_core.sv
core_props.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// File: core_golden.txt
# I program word (hex, from address 0) | D word address, data (hex)
# W register (decimal), value (hex) in write order | S word address, data (hex) in order
I 24017fff I 3c028000 I 3403ffff I 2404ffff  # addiu r1 / lui r2 / ori r3 / addiu r4 = -1
I 00842821 I 00013023 I 0041382a I 0022402a  # addu r5 wraps / subu r6 / slt r7 / slt r8
I 28890000 I 308a8001 I 00615826 I 00446024  # slti r9 / andi r10 / xor r11 / and r12
I 00626825 I 240e0005 I 01ce7821 I 01cf8021  # or r13, then r14..r16 chained
I 01d08821 I 24120040 I 8e530000 I 026ea021  # r17 at distance 3, lw r19, load-use addu r20
I 26950100 I ae550008 I 8e560008 I 24000055  # addiu r21, sw r21, lw r22, addiu r0
I 000eb821 I 11d70003 I 24180001 I 24190bad  # addu r23 reads r0, beq taken, slot, squashed
I 24190bad I 15cf0002 I 241a0002 I 24190bad  # skipped, bne taken, slot, squashed
I 11cf0005 I 241b0003 I 241c0004 I 08000026  # beq not taken, slot, fall through, j 0x98
I 241d0006 I 24190bad I ae5d0000 I 08000027  # slot, squashed, sw r29, spin at 0x9c
I 00000000                                   # spin delay slot
D 10 12345678                                # lw source at byte 0x40
W 1 00007fff W 2 80000000 W 3 0000ffff W 4 ffffffff
W 5 fffffffe W 6 ffff8001 W 7 00000001 W 8 00000000
W 9 00000001 W 10 00008001 W 11 00008000 W 12 80000000
W 13 8000ffff W 14 00000005 W 15 0000000a W 16 0000000f
W 17 00000014 W 18 00000040 W 19 12345678 W 20 1234567d
W 21 1234577d W 22 1234577d W 23 00000005 W 24 00000001
W 26 00000002 W 27 00000003 W 28 00000004 W 29 00000006  # r25 and r0 never written
S 12 1234577d S 10 00000006

// File: core_props.sv
`timescale 1ns/1ps
`default_nettype none

module core_props (
  input logic                     clk,
  input logic                     rst,
  input mips_pipe_pkg::wb_trace_t wb,
  input mips_pipe_pkg::dmem_req_t dmem_req,
  input logic [29:0]              imem_addr,
  input logic                     stall_fde
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  int fail_count = 0; // read by the testbench top at the end

  quiet_after_reset: assert property (@(posedge clk) rst |=> !wb.en && !dmem_req.we)
    else begin fail_count++; $error("write strobe high in the cycle after reset"); end

  no_zero_write: assert property (@(posedge clk) disable iff (rst)
                                  wb.en |-> wb.addr != REG_ZERO)
    else begin fail_count++; $error("register 0 appeared on the write bus"); end

  // held fetch re-requests the word it asked for in the previous cycle
  fetch_held: assert property (@(posedge clk) disable iff (rst)
                               stall_fde |-> $stable(imem_addr))
    else begin fail_count++; $error("fetch address moved during a load-use stall"); end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall_fde,
  input  mips_isa_pkg::word_t      if_inst,
  input  mips_isa_pkg::word_t      if_pc,
  input  logic                     if_valid,
  input  mips_pipe_pkg::wb_trace_t wb,        // reg file write
  output mips_pipe_pkg::id_ex_t    id_ex
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  reg_addr_t dest;
  ctrl_t     ctrl;
  imm_ext_t  imm_sel;
  word_t     imm_ext;
  word_t     rs_data;
  word_t     rt_data;
  word_t     pc_plus_4;

  assign opcode    = opcode_t'(if_inst[31:26]);
  assign funct     = funct_t'(if_inst[5:0]);
  assign rs        = if_inst[25:21];
  assign rt        = if_inst[20:16];
  assign rd        = if_inst[15:11];
  assign dest      = (opcode == OP_SPECIAL) ? rd : rt; // r-type writes rd
  assign pc_plus_4 = if_pc + 32'd4;

  reg_file u_reg_file (
    .clk,
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data,
    .rt_data,
    .wb
  );

  always_comb begin
    ctrl             = '0;
    ctrl.mem_read    = (opcode == OP_LW);
    ctrl.mem_write   = (opcode == OP_SW);
    ctrl.branch_eq   = (opcode == OP_BEQ);
    ctrl.branch_ne   = (opcode == OP_BNE);
    ctrl.jump        = (opcode == OP_J);
    ctrl.reg_dst     = (opcode == OP_SPECIAL);
    ctrl.alu_src_imm = opcode inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_SW};
    ctrl.write_reg   = opcode inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_LW};
    case (opcode)
      OP_SPECIAL: begin
        ctrl.write_reg = 1'b1;
        case (funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.write_reg = 1'b0; // unknown funct, nop
        endcase
      end
      OP_SLTI: ctrl.alu_op = ALU_SLT;
      OP_ANDI: ctrl.alu_op = ALU_AND;
      OP_ORI:  ctrl.alu_op = ALU_OR;
      OP_LUI:  ctrl.alu_op = ALU_LUI;
      default: ctrl.alu_op = ALU_ADD;     // addiu, address calc, unused for branches
    endcase
    if (!if_valid) begin
      ctrl = '0;                          // squashed slot
    end else if (dest == REG_ZERO) begin
      ctrl.write_reg = 1'b0;              // r0 stays zero, never on wb
    end
  end

  always_comb begin
    case (opcode)
      OP_ANDI, OP_ORI: imm_sel = IMM_ZERO;
      OP_LUI:          imm_sel = IMM_UPPER;
      default:         imm_sel = IMM_SIGN;
    endcase
    case (imm_sel)
      IMM_ZERO:  imm_ext = {16'h0000, if_inst[15:0]};
      IMM_UPPER: imm_ext = {if_inst[15:0], 16'h0000};
      default:   imm_ext = {{16{if_inst[15]}}, if_inst[15:0]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else if (stall_fde) begin
      // held op in execute still collects results retiring beneath it
      if (wb.en && wb.addr == id_ex.rs) id_ex.rdata_a <= wb.data;
      if (wb.en && wb.addr == id_ex.rt) id_ex.rdata_b <= wb.data;
    end else begin
      id_ex.valid     <= if_valid;
      id_ex.ctrl      <= ctrl;
      id_ex.rs        <= rs;
      id_ex.rt        <= rt;
      id_ex.rd        <= rd;
      id_ex.rdata_a   <= rs_data;
      id_ex.rdata_b   <= rt_data;
      id_ex.imm       <= imm_ext;
      id_ex.pc_plus_4 <= pc_plus_4;
      id_ex.jump_idx  <= if_inst[25:0];
    end
  end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  mips_pipe_pkg::id_ex_t    id_ex,
  input  mips_isa_pkg::reg_addr_t  mem_dest,      // memory stage destination
  input  logic                     mem_write_reg,
  input  logic                     mem_read,      // memory stage holds a load
  input  mips_isa_pkg::word_t      mem_fwd,       // memory stage alu result
  input  mips_pipe_pkg::wb_trace_t wb,
  output logic                     stall_fde,
  output logic                     branch_taken,
  output mips_isa_pkg::word_t      branch_target,
  output mips_pipe_pkg::dmem_req_t dmem_req,
  output mips_pipe_pkg::ex_mem_t   ex_mem
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;
  word_t     src_a;      // forwarded rs
  word_t     src_b;      // forwarded rt, also store data
  word_t     alu_b;
  word_t     alu_out;
  word_t     br_offset;
  reg_addr_t ex_dest;
  logic      ops_equal;

  // younger producer wins, a load in memory stage is never a source
  function automatic fwd_sel_t fwd_pick(reg_addr_t src);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (wb.en && wb.addr == src) sel = FWD_WB;
    if (mem_write_reg && !mem_read && mem_dest == src) sel = FWD_MEM;
    return sel;
  endfunction

  function automatic word_t fwd_value(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_MEM: return mem_fwd;
      FWD_WB:  return wb.data;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    fwd_a = fwd_pick(id_ex.rs);
    fwd_b = fwd_pick(id_ex.rt);
    src_a = fwd_value(fwd_a, id_ex.rdata_a);
    src_b = fwd_value(fwd_b, id_ex.rdata_b);
  end

  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : src_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: alu_out = src_a + alu_b;        // wraps, no trap
      ALU_SUB: alu_out = src_a - alu_b;
      ALU_AND: alu_out = src_a & alu_b;
      ALU_OR:  alu_out = src_a | alu_b;
      ALU_XOR: alu_out = src_a ^ alu_b;
      ALU_SLT: alu_out = {31'd0, $signed(src_a) < $signed(alu_b)};
      ALU_LUI: alu_out = alu_b;                // extender did the shift
      default: alu_out = src_a + alu_b;
    endcase
  end

  // load in memory stage feeding this op, hold one cycle
  assign stall_fde = id_ex.valid & mem_read & mem_write_reg &
                     ((mem_dest == id_ex.rs) | (mem_dest == id_ex.rt));

  assign ops_equal = (src_a == src_b);
  assign br_offset = {id_ex.imm[29:0], 2'b00};
  assign branch_taken = id_ex.valid & ~stall_fde &
                        (id_ex.ctrl.jump |
                         (id_ex.ctrl.branch_eq &  ops_equal) |
                         (id_ex.ctrl.branch_ne & ~ops_equal));
  assign branch_target = id_ex.ctrl.jump ?
                         {id_ex.pc_plus_4[31:28], id_ex.jump_idx, 2'b00} :
                         id_ex.pc_plus_4 + br_offset;

  assign ex_dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

  // no request while stalled, address may be stale
  assign dmem_req = '{re:    id_ex.valid & id_ex.ctrl.mem_read & ~stall_fde,
                      we:    id_ex.valid & id_ex.ctrl.mem_write & ~stall_fde,
                      addr:  alu_out[31:2],
                      wdata: src_b};

  always_ff @(posedge clk) begin
    if (rst || stall_fde) begin
      ex_mem.valid     <= 1'b0;              // bubble into memory stage
      ex_mem.write_reg <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.write_reg  <= id_ex.ctrl.write_reg;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.dest       <= ex_dest;
      ex_mem.alu_result <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall_fde,     // load-use hold
  input  logic                branch_taken,  // redirect from execute
  input  mips_isa_pkg::word_t branch_target,
  output logic [29:0]         imem_addr,     // word address, data returns next cycle
  input  mips_isa_pkg::word_t imem_data,
  output mips_isa_pkg::word_t if_inst,
  output mips_isa_pkg::word_t if_pc,
  output logic                if_valid
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  word_t pc;        // address of the word now on imem_data
  word_t next_pc;
  word_t inst_sel;
  logic  fetch_run; // low in the first cycle after reset, memory still priming

  always_comb begin
    if (!fetch_run || stall_fde) begin
      next_pc = pc;                    // refetch same word
    end else if (branch_taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  assign imem_addr = next_pc[31:2];
  assign inst_sel  = stall_fde ? if_inst : imem_data; // recirculate while held

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= RESET_PC;
      fetch_run <= 1'b0;
      if_inst   <= '0;                 // sll r0 bubble
      if_pc     <= RESET_PC;
      if_valid  <= 1'b0;
    end else begin
      pc        <= next_pc;
      fetch_run <= 1'b1;
      if_inst   <= (branch_taken || !fetch_run) ? '0 : inst_sel; // squash behind delay slot
      if (!stall_fde) begin
        if_pc    <= pc;
        if_valid <= fetch_run & ~branch_taken;
      end
    end
  end

endmodule

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
  input  logic                     clk,
  input  logic                     rst,
  output logic [29:0]              imem_addr,  // next pc, word address
  input  mips_isa_pkg::word_t      imem_data,
  output mips_pipe_pkg::dmem_req_t dmem_req,
  input  mips_isa_pkg::word_t      dmem_rdata,
  output mips_pipe_pkg::wb_trace_t wb          // reg file write bus
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  word_t     if_inst;
  word_t     if_pc;
  logic      if_valid;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  logic      stall_fde;
  logic      branch_taken;
  word_t     branch_target;
  reg_addr_t mem_dest;
  logic      mem_write_reg;
  logic      mem_read;
  word_t     mem_fwd;

  fetch_unit u_fetch (
    .clk, .rst, .stall_fde, .branch_taken, .branch_target,
    .imem_addr, .imem_data, .if_inst, .if_pc, .if_valid
  );

  decode_stage u_decode (
    .clk, .rst, .stall_fde, .if_inst, .if_pc, .if_valid,
    .wb, .id_ex
  );

  execute_stage u_execute (
    .clk, .rst, .id_ex, .mem_dest, .mem_write_reg, .mem_read, .mem_fwd,
    .wb, .stall_fde, .branch_taken, .branch_target, .dmem_req, .ex_mem
  );

  result_stage u_result (
    .clk, .rst, .ex_mem, .dmem_rdata,
    .mem_dest, .mem_write_reg, .mem_read, .mem_fwd, .wb
  );

endmodule

`default_nettype wire

// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;     // data or byte address
  typedef logic [4:0]  reg_addr_t; // gpr index

  // primary opcodes, inst[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type, see funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  // r-type function codes, inst[5:0]
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, // no overflow trap, addu semantics
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT, // signed compare
    ALU_LUI  // passes operand b, already shifted by the extender
  } alu_op_t;

  typedef enum logic [1:0] {
    IMM_SIGN,  // arith, loads, stores, branches
    IMM_ZERO,  // andi, ori
    IMM_UPPER  // lui
  } imm_ext_t;

  localparam reg_addr_t REG_ZERO = 5'd0; // hard-wired zero

endpackage

`default_nettype wire

// File: mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

  localparam mips_isa_pkg::word_t RESET_PC = 32'h0000_0000;

  typedef struct packed {
    logic                  write_reg;   // writes gpr at writeback
    logic                  reg_dst;     // 1 = rd, 0 = rt
    mips_isa_pkg::alu_op_t alu_op;
    logic                  alu_src_imm; // operand b from immediate
    logic                  mem_read;    // lw
    logic                  mem_write;   // sw
    logic                  branch_ne;
    logic                  branch_eq;
    logic                  jump;        // j, 26-bit index
  } ctrl_t;

  typedef struct packed {
    logic                    valid;
    ctrl_t                   ctrl;
    mips_isa_pkg::reg_addr_t rs;
    mips_isa_pkg::reg_addr_t rt;
    mips_isa_pkg::reg_addr_t rd;
    mips_isa_pkg::word_t     rdata_a;   // rs from reg file
    mips_isa_pkg::word_t     rdata_b;   // rt from reg file
    mips_isa_pkg::word_t     imm;       // extended immediate
    mips_isa_pkg::word_t     pc_plus_4; // delay slot address
    logic [25:0]             jump_idx;
  } id_ex_t;

  typedef struct packed {
    logic                    valid;
    logic                    write_reg;
    logic                    mem_read;
    mips_isa_pkg::reg_addr_t dest;
    mips_isa_pkg::word_t     alu_result; // also the load address
  } ex_mem_t;

  typedef struct packed {
    logic                    write_reg;
    logic                    mem_read;  // selects load_data at writeback
    mips_isa_pkg::reg_addr_t dest;
    mips_isa_pkg::word_t     alu_result;
    mips_isa_pkg::word_t     load_data;
  } mem_wb_t;

  typedef enum logic [1:0] {
    FWD_NONE, // reg file value
    FWD_MEM,  // alu result in memory stage
    FWD_WB    // writeback bus
  } fwd_sel_t;

  typedef struct packed {
    logic                re;
    logic                we;
    logic [29:0]         addr;  // word address
    mips_isa_pkg::word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic                    en;
    mips_isa_pkg::reg_addr_t addr;
    mips_isa_pkg::word_t     data;
  } wb_trace_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                      clk,
  input  mips_isa_pkg::reg_addr_t   rs_addr,
  input  mips_isa_pkg::reg_addr_t   rt_addr,
  output mips_isa_pkg::word_t       rs_data,
  output mips_isa_pkg::word_t       rt_data,
  input  mips_pipe_pkg::wb_trace_t  wb       // write port
);
  import mips_isa_pkg::*;

  word_t regs [32];

  // r0 reads zero, same-cycle write passes straight through
  function automatic word_t read_port(reg_addr_t a);
    if (a == REG_ZERO) return '0;
    if (wb.en && wb.addr == a) return wb.data;
    return regs[a];
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  always_ff @(posedge clk) begin
    if (wb.en) regs[wb.addr] <= wb.data; // en never set for r0
  end

endmodule

`default_nettype wire

// File: result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  mips_pipe_pkg::ex_mem_t   ex_mem,
  input  mips_isa_pkg::word_t      dmem_rdata,    // valid the cycle after re
  output mips_isa_pkg::reg_addr_t  mem_dest,
  output logic                     mem_write_reg,
  output logic                     mem_read,
  output mips_isa_pkg::word_t      mem_fwd,
  output mips_pipe_pkg::wb_trace_t wb
);
  import mips_pipe_pkg::*;

  mem_wb_t mem_wb;

  // memory stage view for forwarding and load-use check
  assign mem_dest      = ex_mem.dest;
  assign mem_write_reg = ex_mem.valid & ex_mem.write_reg;
  assign mem_read      = ex_mem.valid & ex_mem.mem_read;
  assign mem_fwd       = ex_mem.alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb.write_reg <= 1'b0;
      mem_wb.mem_read  <= 1'b0;
    end else begin
      mem_wb.write_reg  <= mem_write_reg;
      mem_wb.mem_read   <= mem_read;
      mem_wb.dest       <= ex_mem.dest;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= dmem_rdata;       // whole word, no byte lanes
    end
  end

  // writeback straight out of the register
  assign wb = '{en:   mem_wb.write_reg,
                addr: mem_wb.dest,
                data: mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result};

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  mips_pipe_pkg::wb_trace_t wb,
  input  mips_pipe_pkg::dmem_req_t dmem_req,
  output logic                     done,          // both expectation lists consumed
  output int                       wrong_values,
  output int                       extra_events
);
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  localparam int TABLE_DEPTH = 64;

  wb_trace_t exp_w [TABLE_DEPTH]; // register writes, program order
  dmem_req_t exp_s [TABLE_DEPTH]; // stores, program order
  int        n_w = 0;
  int        n_s = 0;
  int        w_idx = 0;           // next expected write
  int        s_idx = 0;
  int        wrong_count = 0;
  int        extra_count = 0;

  assign done         = (w_idx >= n_w) && (s_idx >= n_s);
  assign wrong_values = wrong_count;
  assign extra_events = extra_count;

  task automatic expect_reg_write(input reg_addr_t addr, input word_t data);
    if (n_w < TABLE_DEPTH) begin
      exp_w[n_w] = '{en: 1'b1, addr: addr, data: data};
      n_w++;
    end else begin
      $display("golden file holds more than %0d register writes", TABLE_DEPTH);
    end
  endtask

  task automatic expect_store(input logic [29:0] addr, input word_t data);
    if (n_s < TABLE_DEPTH) begin
      exp_s[n_s] = '{re: 1'b0, we: 1'b1, addr: addr, wdata: data};
      n_s++;
    end else begin
      $display("golden file holds more than %0d stores", TABLE_DEPTH);
    end
  endtask

  task automatic check_reg_write();
    wb_trace_t e;
    if (w_idx >= n_w) begin
      $display("unexpected register write r%0d = %h at %0t ns, none left to match",
               wb.addr, wb.data, $time);
      extra_count++;
    end else begin
      e = exp_w[w_idx];
      if (wb.addr !== e.addr || wb.data !== e.data) begin
        $display("FAILED at %0t ns: write %0d expected r%0d = %h, got r%0d = %h",
                 $time, w_idx, e.addr, e.data, wb.addr, wb.data);
        wrong_count++;
      end
      w_idx++;
    end
  endtask

  task automatic check_store();
    dmem_req_t e;
    if (s_idx >= n_s) begin
      $display("unexpected store of %h to word %h at %0t ns, none left to match",
               dmem_req.wdata, dmem_req.addr, $time);
      extra_count++;
    end else begin
      e = exp_s[s_idx];
      if (dmem_req.addr !== e.addr || dmem_req.wdata !== e.wdata) begin
        $display("FAILED at %0t ns: store %0d expected [%h] = %h, got [%h] = %h",
                 $time, s_idx, e.addr, e.wdata, dmem_req.addr, dmem_req.wdata);
        wrong_count++;
      end
      s_idx++;
    end
  endtask

  // called once at the end of the run
  task automatic report_missing(output int missing);
    missing = (n_w - w_idx) + (n_s - s_idx);
    if (w_idx < n_w)
      $display("%0d of %0d expected register writes never appeared", n_w - w_idx, n_w);
    if (s_idx < n_s)
      $display("%0d of %0d expected stores never appeared", n_s - s_idx, n_s);
  endtask

  always @(posedge clk) begin       // values settled since the falling edge
    if (!rst) begin
      if (wb.en === 1'b1) check_reg_write();
      if (dmem_req.we === 1'b1) check_store();
    end
  end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD  = 20; // 40 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released on a falling edge like all stimulus
  end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam     GOLDEN_FILE = "core_golden.txt";

  logic        clk;
  logic        rst;
  logic [29:0] imem_addr;
  word_t       imem_data;
  dmem_req_t   dmem_req;
  word_t       dmem_rdata;
  wb_trace_t   wb;
  word_t       imem [MEM_WORDS];
  word_t       dmem [MEM_WORDS];
  logic [7:0]  iaddr_q;          // address latched on the rising edge
  logic [7:0]  daddr_q;
  logic        dread_q;          // read strobe seen on the rising edge
  logic        loaded;
  logic        done;
  int          wrong_values;
  int          extra_events;
  int          n_prog;
  int          cycle_limit;

  tb_clock u_clock (.clk, .rst);

  mips_core DUT (
    .clk, .rst, .imem_addr, .imem_data, .dmem_req, .dmem_rdata, .wb
  );

  bind mips_core core_props u_props (
    .clk, .rst, .wb, .dmem_req, .imem_addr, .stall_fde
  );

  tb_checker u_checker (
    .clk, .rst, .wb, .dmem_req, .done, .wrong_values, .extra_events
  );

  // one-cycle synchronous memories, read data driven on the falling edge
  always @(posedge clk) begin
    iaddr_q <= imem_addr[7:0];
    daddr_q <= dmem_req.addr[7:0];
    dread_q <= (dmem_req.re === 1'b1);
    if (dmem_req.we === 1'b1) dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
  end

  always @(negedge clk) begin
    imem_data  = imem[iaddr_q];
    dmem_rdata = dread_q ? dmem[daddr_q] : 'x; // data only for a requested read
  end

  task automatic load_golden(output bit ok);
    int                 fd;
    int                 code;
    logic [7:0]         tag;
    logic [31:0]        a;
    logic [31:0]        d;
    logic [8*128-1:0]   rest;
    bit                 eof;
    ok  = 1'b0;
    eof = 1'b0;
    fd  = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) return;
    ok = 1'b1;
    while (!eof) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) begin
        eof = 1'b1;
      end else begin
        case (tag)
          "#": code = $fgets(rest, fd);          // comment to end of line
          "I": begin
            code = $fscanf(fd, "%h", d);
            imem[n_prog[7:0]] = d;
            n_prog++;
          end
          "D": begin
            code = $fscanf(fd, "%h %h", a, d);
            dmem[a[7:0]] = d;
          end
          "W": begin
            code = $fscanf(fd, "%d %h", a, d);
            u_checker.expect_reg_write(a[4:0], d);
          end
          "S": begin
            code = $fscanf(fd, "%h %h", a, d);
            u_checker.expect_store(a[29:0], d);
          end
          default: begin
            $display("golden file has an unknown line tag '%c'", tag);
            ok  = 1'b0;
            eof = 1'b1;
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  task automatic finish_run(input bit aborted);
    int missing;
    int props_failed;
    u_checker.report_missing(missing);
    props_failed = DUT.u_props.fail_count;
    $display("closing: %0d wrong values, %0d extra events, %0d missing events, %0d assertion fails",
             wrong_values, extra_events, missing, props_failed);
    if (aborted || (wrong_values + extra_events + missing + props_failed) != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    loaded     = 1'b0;
    imem_data  = '0;
    dmem_rdata = '0;
    iaddr_q    = '0;
    daddr_q    = '0;
    dread_q    = 1'b0;
    n_prog     = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {21'd0, i[10:0]};   // r-type with rd = 0, a nop
      dmem[i] = 32'hd000_0000 | i;
    end
    load_golden(ok);
    if (!ok) begin
      $display("could not read the stimulus from %s", GOLDEN_FILE);
      finish_run(1'b1);
    end else begin
      cycle_limit = n_prog * 3 + 50;
      loaded      = 1'b1;
      @(negedge rst);
      wait (done);
      repeat (10) @(posedge clk);   // room for stray writes to show up
      finish_run(1'b0);
    end
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (cycle_limit) @(posedge clk);
    $display("timeout: program did not complete within %0d clock cycles", cycle_limit);
    finish_run(1'b1);
  end

endmodule

`default_nettype wire
